/* files.f */
+incdir+include
rtl/plic_pkg.sv
rtl/plic_gw_if.sv
rtl/irq_gateway.sv
rtl/plic_core.sv
rtl/plic_top.sv
verif/plic_assertions.sv
verif/tb_plic_top.sv

/* verif/tb_plic_top.sv */
// Directed testbench for the PLIC subsystem with bus, claim and complete checks
`timescale 1ns/10ps
`include "plic_cfg.svh"

module tb_plic_top;

    logic               clk_i;
    logic               rst_ni;
    plic_pkg::irq_vec_t irq_src;
    logic [31:0]        addr;
    logic               wr_en;
    logic               rd_en;
    logic [31:0]        wr_data;
    logic [31:0]        rd_data;
    logic               irq;

    plic_pkg::prio_t    prio_cfg [1:`PLIC_NUM_IRQ];  // Values last programmed
    plic_pkg::irq_vec_t enable_cfg;
    plic_pkg::prio_t    thr_cfg;
    logic [31:0]        lfsr_q;
    int                 checks;
    int                 errors;
    int                 test_start;

    plic_top UUT (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .irq_src (irq_src),
        .addr    (addr),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .irq     (irq)
    );

    bind irq_gateway plic_assertions u_handshake_sva (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .pending     (gw.pending),
        .in_service  (in_service_q),
        .claim_valid (gw.claim_valid),
        .claim_id    (gw.claim_id)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    // Galois LFSR, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] prio_addr(int id);
        return `PLIC_ADDR_PRIORITY_BASE + 32'(4 * (id - 1));
    endfunction

    // Highest eligible priority first, then the lowest ID holding it
    function automatic plic_pkg::irq_id_t expected_claim(plic_pkg::irq_vec_t src);
        int best_p;
        best_p = -1;
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            if (src[i] && enable_cfg[i] && prio_cfg[i] > thr_cfg && int'(prio_cfg[i]) > best_p) begin
                best_p = int'(prio_cfg[i]);
            end
        end
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            if (src[i] && enable_cfg[i] && prio_cfg[i] > thr_cfg && int'(prio_cfg[i]) == best_p) begin
                return plic_pkg::irq_id_t'(i);
            end
        end
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error: t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            $display("t=%0t %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%-24s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [31:0] d);
        @(posedge clk_i);
        addr    <= a;
        wr_data <= d;
        wr_en   <= 1'b1;
        @(posedge clk_i);  // Write lands on this edge
        wr_en   <= 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d);
        @(posedge clk_i);
        addr  <= a;
        rd_en <= 1'b1;
        @(posedge clk_i);
        rd_en <= 1'b0;
        @(negedge clk_i);  // rd_data settled
        d = rd_data;
    endtask

    task automatic claim(output logic [31:0] id);
        bus_read(`PLIC_ADDR_CLAIM, id);
    endtask

    task automatic complete(input logic [31:0] id);
        bus_write(`PLIC_ADDR_CLAIM, id);
    endtask

    task automatic set_sources(input plic_pkg::irq_vec_t src);
        @(posedge clk_i);
        irq_src <= src;
    endtask

    task automatic program_regs();
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            bus_write(prio_addr(i), 32'(prio_cfg[i]));
        end
        bus_write(`PLIC_ADDR_ENABLE, 32'(enable_cfg));
        bus_write(`PLIC_ADDR_THRESHOLD, 32'(thr_cfg));
    endtask

    task automatic wait_irq(input logic exp, input int max_cycles);
        int  n;
        bit  seen;
        n    = 0;
        seen = 0;
        while (!seen && n < max_cycles) begin
            @(negedge clk_i);
            n++;
            seen = (irq === exp);
        end
        check_true(seen, $sformatf("irq did not become %b within %0d cycles", exp, max_cycles));
    endtask

    task automatic wait_pending(input plic_pkg::irq_vec_t exp, input int max_reads);
        logic [31:0] val;
        int          n;
        bit          seen;
        n    = 0;
        seen = 0;
        while (!seen && n < max_reads) begin
            bus_read(`PLIC_ADDR_PENDING, val);
            n++;
            seen = (val === 32'(exp));
        end
        check_true(seen, $sformatf("pending did not reach %h within %0d reads", exp, max_reads));
    endtask

    task automatic reset_state();
        logic [31:0] v;
        @(negedge clk_i);
        check_value("irq", 32'(irq), 32'd0);
        bus_read(`PLIC_ADDR_PENDING, v);
        check_value("pending", v, 32'd0);
        bus_read(`PLIC_ADDR_ENABLE, v);
        check_value("enable", v, 32'd0);
        bus_read(`PLIC_ADDR_THRESHOLD, v);
        check_value("threshold", v, 32'd0);
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            bus_read(prio_addr(i), v);
            check_value($sformatf("priority[%0d]", i), v, 32'd0);
        end
        claim(v);
        check_value("claim", v, 32'd0);
        report_test("reset_state");
    endtask

    task automatic register_access();
        logic [31:0] v;
        logic [31:0] prio_mask;
        logic [31:0] en_mask;
        prio_mask = (32'd1 << `PLIC_PRIO_W) - 1;
        en_mask   = ((32'd1 << (`PLIC_NUM_IRQ + 1)) - 1) & ~32'd1;
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            bus_write(prio_addr(i), 32'hdead_bee0 | 32'(i));  // Upper bits must drop
        end
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            bus_read(prio_addr(i), v);
            check_value($sformatf("priority[%0d]", i), v, (32'hdead_bee0 | 32'(i)) & prio_mask);
        end
        bus_write(`PLIC_ADDR_ENABLE, 32'hffff_ffff);
        bus_read(`PLIC_ADDR_ENABLE, v);
        check_value("enable", v, en_mask);
        bus_write(`PLIC_ADDR_THRESHOLD, 32'h0000_00fd);
        bus_read(`PLIC_ADDR_THRESHOLD, v);
        check_value("threshold", v, 32'h0000_00fd & prio_mask);
        bus_read(32'h0000_0000, v);
        check_value("unmapped 0x0", v, 32'd0);
        bus_read(32'h0000_3000, v);
        check_value("unmapped 0x3000", v, 32'd0);
        bus_read(prio_addr(`PLIC_NUM_IRQ + 1), v);
        check_value("unmapped past last priority", v, 32'd0);
        check_value("irq", 32'(irq), 32'd0);  // No source is high
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            prio_cfg[i] = '0;
        end
        enable_cfg = '0;
        thr_cfg    = '0;
        program_regs();
        report_test("register_access");
    endtask

    task automatic arbitration();
        logic [31:0]        v;
        plic_pkg::irq_vec_t src;
        plic_pkg::irq_id_t  exp;
        prio_cfg[1] = 3;
        prio_cfg[2] = 5;
        prio_cfg[3] = 5;  // Ties with ID 2
        prio_cfg[4] = 2;
        prio_cfg[5] = 7;  // Masked off below
        prio_cfg[6] = 1;  // Equal to threshold
        prio_cfg[7] = 0;
        enable_cfg = plic_pkg::irq_vec_t'(8'hde);
        thr_cfg    = 1;
        program_regs();
        src = plic_pkg::irq_vec_t'(8'h7e);
        exp = expected_claim(src);
        set_sources(src);
        wait_pending(src, 6);
        check_value("irq", 32'(irq), 32'd1);
        claim(v);
        check_value("claim id", v, 32'(exp));
        set_sources('0);
        idle(3);
        complete(32'(exp));
        wait_pending('0, 6);
        // Only masked, at-threshold and below-threshold sources
        src = plic_pkg::irq_vec_t'(8'he0);
        set_sources(src);
        wait_pending(src, 6);
        check_value("irq", 32'(irq), 32'd0);
        claim(v);
        check_value("claim id", v, 32'd0);
        bus_read(`PLIC_ADDR_PENDING, v);
        check_value("pending", v, 32'(src));
        set_sources('0);
        wait_pending('0, 6);
        report_test("arbitration");
    endtask

    task automatic claim_complete_gating();
        logic [31:0] v;
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            prio_cfg[i] = '0;
        end
        prio_cfg[3] = 4;
        enable_cfg  = plic_pkg::irq_vec_t'(8'h08);
        thr_cfg     = 0;
        program_regs();
        set_sources(plic_pkg::irq_vec_t'(8'h08));
        wait_irq(1'b1, 4);  // Drive cycle, two sync stages, then the latch
        claim(v);
        check_value("claim id", v, 32'd3);
        wait_irq(1'b0, 1);
        for (int k = 0; k < 5; k++) begin
            bus_read(`PLIC_ADDR_PENDING, v);
            check_value("pending", v, 32'd0);
            check_value("irq", 32'(irq), 32'd0);
        end
        complete(32'd5);  // Wrong ID, source stays in service
        idle(4);
        bus_read(`PLIC_ADDR_PENDING, v);
        check_value("pending", v, 32'd0);
        check_value("irq", 32'(irq), 32'd0);
        complete(32'd3);
        wait_irq(1'b1, 3);
        bus_read(`PLIC_ADDR_PENDING, v);
        check_value("pending", v, 32'h0000_0008);
        claim(v);
        check_value("claim id", v, 32'd3);
        set_sources('0);
        idle(3);
        complete(32'd3);
        wait_pending('0, 6);
        check_value("irq", 32'(irq), 32'd0);
        report_test("claim_complete_gating");
    endtask

    task automatic random_arbitration();
        logic [31:0]        v;
        plic_pkg::irq_vec_t src;
        plic_pkg::irq_id_t  exp;
        for (int r = 0; r < 20; r++) begin
            for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
                prio_cfg[i] = plic_pkg::prio_t'(take_bits(`PLIC_PRIO_W));
            end
            enable_cfg = plic_pkg::irq_vec_t'(take_bits(`PLIC_NUM_IRQ) << 1);
            thr_cfg    = plic_pkg::prio_t'(take_bits(`PLIC_PRIO_W - 1));  // Keeps some hits
            src        = plic_pkg::irq_vec_t'(take_bits(`PLIC_NUM_IRQ) << 1);
            program_regs();
            exp = expected_claim(src);
            set_sources(src);
            wait_pending(src, 6);
            check_value($sformatf("irq round %0d", r), 32'(irq), 32'(exp != '0));
            claim(v);
            check_value($sformatf("claim id round %0d", r), v, 32'(exp));
            set_sources('0);
            idle(3);
            if (exp != '0) begin
                complete(32'(exp));
            end
            wait_pending('0, 6);
        end
        report_test("random_arbitration");
    endtask

    initial begin
        rst_ni     = 1'b0;
        irq_src    = '0;
        addr       = '0;
        wr_en      = 1'b0;
        rd_en      = 1'b0;
        wr_data    = '0;
        lfsr_q     = 32'hf30d_4a73;
        checks     = 0;
        errors     = 0;
        test_start = 0;
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        reset_state();
        register_access();
        arbitration();
        claim_complete_gating();
        random_arbitration();
        errors += UUT.u_gateway.u_handshake_sva.fail_count;  // Bound handshake checks
        $display("summary: 5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verif/plic_assertions.sv */
// Bound checks on the gateway side of the gateway/core claim handshake
`timescale 1ns/10ps

module plic_assertions (
    input logic               clk_i,
    input logic               rst_ni,
    input plic_pkg::irq_vec_t pending,
    input plic_pkg::irq_vec_t in_service,
    input logic               claim_valid,
    input plic_pkg::irq_id_t  claim_id
);

    int fail_count;  // Failed assertion count

    initial begin
        fail_count = 0;
    end

    // A source in service last cycle cannot show as pending now
    pending_gated_in_service: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (pending & $past(in_service)) == '0
    ) else begin
        $error("pending bit set while its source was in service");
        fail_count++;
    end

    // The claimed ID was pending when the claim read was decoded
    claim_of_pending_id: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        claim_valid |-> ($past(pending) & plic_pkg::id_to_vec(claim_id)) != '0
    ) else begin
        $error("claim strobe for ID %0d that was not pending", claim_id);
        fail_count++;
    end

    // No request right after reset, so the core keeps irq low
    quiet_after_reset: assert property (
        @(posedge clk_i)
        $rose(rst_ni) |=> pending == '0
    ) else begin
        $error("pending request in the cycle after reset, irq not held low");
        fail_count++;
    end

endmodule

/* rtl/plic_top.sv */
// PLIC subsystem top joining the interrupt gateway and the register core
`timescale 1ns/10ps

module plic_top (
    input  logic               clk_i,
    input  logic               rst_ni,

    // Level-sensitive sources, bit 0 unused
    input  plic_pkg::irq_vec_t irq_src,

    // Register bus, one-cycle read latency
    input  logic [31:0]        addr,
    input  logic               wr_en,
    input  logic               rd_en,
    input  logic [31:0]        wr_data,
    output logic [31:0]        rd_data,

    // CPU interrupt line
    output logic               irq
);

    // Pending requests and claim/complete strobes
    plic_gw_if gw_if ();

    irq_gateway u_gateway (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .irq_src (irq_src),
        .gw      (gw_if.gateway)
    );

    plic_core u_core (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .gw      (gw_if.core),
        .addr    (addr),
        .wr_en   (wr_en),
        .rd_en   (rd_en),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .irq     (irq)
    );

endmodule

/* rtl/plic_core.sv */
// PLIC core with register file, priority arbitration and claim/complete handling
`timescale 1ns/10ps
`include "plic_cfg.svh"

module plic_core (
    input  logic        clk_i,
    input  logic        rst_ni,
    plic_gw_if.core     gw,
    input  logic [31:0] addr,
    input  logic        wr_en,
    input  logic        rd_en,
    input  logic [31:0] wr_data,
    output logic [31:0] rd_data,
    output logic        irq
);

    plic_pkg::prio_t    prio_q [1:`PLIC_NUM_IRQ];  // Priority per source
    plic_pkg::irq_vec_t enable_q;                  // Enable mask, bit 0 stays zero
    plic_pkg::prio_t    threshold_q;

    plic_pkg::irq_vec_t prio_sel;                  // One-hot priority register hit
    plic_pkg::irq_id_t  best_id;
    plic_pkg::prio_t    best_prio;
    logic [31:0]        rd_next;
    logic               claim_rd;
    logic               complete_wr;

    // Priority register address decode
    always_comb begin
        prio_sel = '0;
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            prio_sel[i] = (addr == `PLIC_ADDR_PRIORITY_BASE + 32'(4 * (i - 1)));
        end
    end

    // Arbitration. Starting from the threshold makes "strictly above" fall out,
    // and the strict compare keeps the lowest ID on a tie
    always_comb begin
        best_id   = '0;
        best_prio = threshold_q;
        for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
            if (gw.pending[i] && enable_q[i] && (prio_q[i] > best_prio)) begin
                best_id   = plic_pkg::irq_id_t'(i);
                best_prio = prio_q[i];
            end
        end
    end

    assign irq = (best_id != '0);  // Single CPU context

    assign claim_rd    = rd_en && (addr == `PLIC_ADDR_CLAIM);
    assign complete_wr = wr_en && (addr == `PLIC_ADDR_CLAIM);

    // Read data mux
    always_comb begin
        rd_next = '0;  // Unmapped reads return zero
        case (addr)
            `PLIC_ADDR_PENDING: begin
                rd_next = 32'(gw.pending);
            end
            `PLIC_ADDR_ENABLE: begin
                rd_next = 32'(enable_q);
            end
            `PLIC_ADDR_THRESHOLD: begin
                rd_next = 32'(threshold_q);
            end
            `PLIC_ADDR_CLAIM: begin
                rd_next = 32'(best_id);  // Claim returns current winner
            end
            default: begin
                for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
                    if (prio_sel[i]) begin
                        rd_next = 32'(prio_q[i]);
                    end
                end
            end
        endcase
    end

    // Register writes, fields keep only their low bits
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
                prio_q[i] <= '0;
            end
            enable_q    <= '0;
            threshold_q <= '0;
        end else if (wr_en) begin
            if (addr == `PLIC_ADDR_ENABLE) begin
                enable_q <= plic_pkg::irq_vec_t'(wr_data) & plic_pkg::src_mask;
            end
            if (addr == `PLIC_ADDR_THRESHOLD) begin
                threshold_q <= plic_pkg::prio_t'(wr_data);
            end
            for (int i = 1; i <= `PLIC_NUM_IRQ; i++) begin
                if (prio_sel[i]) begin
                    prio_q[i] <= plic_pkg::prio_t'(wr_data);
                end
            end
        end
    end

    // Read data and strobes, all one cycle after the bus access
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            rd_data           <= '0;
            gw.claim_valid    <= 1'b0;
            gw.claim_id       <= '0;
            gw.complete_valid <= 1'b0;
            gw.complete_id    <= '0;
        end else begin
            if (rd_en) begin
                rd_data <= rd_next;  // Held until the next read
            end
            gw.claim_valid    <= claim_rd && (best_id != '0);  // No strobe for ID 0
            gw.claim_id       <= best_id;
            gw.complete_valid <= complete_wr;
            gw.complete_id    <= plic_pkg::irq_id_t'(wr_data);
        end
    end

endmodule

/* rtl/irq_gateway.sv */
// Interrupt gateway that synchronizes level sources and gates them while in service
`timescale 1ns/10ps

module irq_gateway (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  plic_pkg::irq_vec_t irq_src,
    plic_gw_if.gateway         gw
);

    plic_pkg::irq_vec_t sync1_q;        // First synchronizer stage
    plic_pkg::irq_vec_t sync2_q;        // Second stage, safe to use
    plic_pkg::irq_vec_t in_service_q;   // Claimed and not yet completed
    plic_pkg::irq_vec_t claim_vec;
    plic_pkg::irq_vec_t complete_vec;
    plic_pkg::irq_vec_t pending_d;
    plic_pkg::irq_vec_t in_service_d;

    // Decode the strobes into one-hot source vectors
    always_comb begin
        claim_vec    = '0;
        complete_vec = '0;
        if (gw.claim_valid) begin
            claim_vec = plic_pkg::id_to_vec(gw.claim_id);
        end
        if (gw.complete_valid) begin
            complete_vec = plic_pkg::id_to_vec(gw.complete_id);
        end
    end

    // A claim takes the source in service, a complete only frees a source
    // that is actually in service, so a stray ID leaves the state alone
    always_comb begin
        in_service_d = (in_service_q & ~(complete_vec & in_service_q)) | claim_vec;
    end

    // Pending tracks the gated level, claim clears it in the same edge
    always_comb begin
        pending_d = sync2_q & ~in_service_q & ~claim_vec;
    end

    // Two-flop synchronizer, keeps running while a source is in service
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= irq_src & plic_pkg::src_mask;  // Drop ID 0
            sync2_q <= sync1_q;
        end
    end

    // Pending latch and in-service state
    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            gw.pending   <= '0;
            in_service_q <= '0;
        end else begin
            gw.pending   <= pending_d;
            in_service_q <= in_service_d;
        end
    end

endmodule

/* rtl/plic_gw_if.sv */
// Gateway to core link carrying pending requests and claim/complete strobes
`timescale 1ns/10ps

interface plic_gw_if;

    // Gateway side
    plic_pkg::irq_vec_t pending;         // Latched requests, bit 0 always zero

    // Core side, single-cycle strobes
    logic               claim_valid;     // Claim read accepted
    plic_pkg::irq_id_t  claim_id;        // ID handed to the CPU
    logic               complete_valid;  // Write to claim register
    plic_pkg::irq_id_t  complete_id;     // ID the CPU is done with

    modport gateway (
        output pending,
        input  claim_valid,
        input  claim_id,
        input  complete_valid,
        input  complete_id
    );

    modport core (
        input  pending,
        output claim_valid,
        output claim_id,
        output complete_valid,
        output complete_id
    );

endinterface

/* rtl/plic_pkg.sv */
// Shared PLIC types and helpers for source vectors, IDs and priorities
`include "plic_cfg.svh"

package plic_pkg;

    // One bit per source ID, bit 0 unused
    typedef logic [`PLIC_NUM_IRQ:0] irq_vec_t;

    // Source ID, 0 means no interrupt
    typedef logic [`PLIC_ID_W-1:0] irq_id_t;

    // Priority or threshold value
    typedef logic [`PLIC_PRIO_W-1:0] prio_t;

    // Valid source bits, ID 0 never carries a request
    parameter irq_vec_t src_mask = ~irq_vec_t'(1);

    // One-hot vector for a source ID, empty for ID 0 or out of range
    function automatic irq_vec_t id_to_vec(irq_id_t id);
        irq_vec_t vec;
        vec = '0;
        if (id != '0 && int'(id) <= `PLIC_NUM_IRQ) begin
            vec[id] = 1'b1;
        end
        return vec;
    endfunction

endpackage

/* include/plic_cfg.svh */
// PLIC configuration macros for source count, field widths and register map
`ifndef PLIC_CFG_SVH
`define PLIC_CFG_SVH

// Number of interrupt sources, IDs 1..N with ID 0 reserved for no interrupt
`define PLIC_NUM_IRQ 7

// Priority and threshold width
`define PLIC_PRIO_W 3

// Source ID width, must hold PLIC_NUM_IRQ
`define PLIC_ID_W 3

// Priority of source n lives at base + 4*(n-1)
`define PLIC_ADDR_PRIORITY_BASE 32'h0000_0004

// Read-only pending vector
`define PLIC_ADDR_PENDING 32'h0000_1000

// Enable mask for the single context
`define PLIC_ADDR_ENABLE 32'h0000_2000

// Priority threshold
`define PLIC_ADDR_THRESHOLD 32'h0020_0000

// Claim on read, complete on write
`define PLIC_ADDR_CLAIM 32'h0020_0004

`endif
